// File: rtl/dcache_cfg.svh
/*
 * data cache geometry
 * two ways, sixteen sets, four-word lines on a 32-bit address
 */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and data word width
`define DCACHE_ADDR_W 32

`define DCACHE_WAYS 2
`define DCACHE_SETS 16
`define DCACHE_LINE_WORDS 4

// byte offset within a line, set index, and what remains for the tag
`define DCACHE_OFFSET_W 4
`define DCACHE_INDEX_W 4
`define DCACHE_TAG_W 24

`endif

// File: rtl/dcache_addr_pkg.sv
/*
 * data cache address types
 * address decode, tag entry, line and way-select types
 */
`default_nettype none

`include "dcache_cfg.svh"

package dcache_addr_pkg;

    // tag / index / byte offset view of an address
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // the same word seen raw or split into fields
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } addr_u;

    typedef struct packed {
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tagv_t;

    // word 0 sits in the low bits
    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_ADDR_W-1:0] line_t;

    typedef logic [`DCACHE_WAYS-1:0] way_sel_t;

endpackage

`default_nettype wire

// File: rtl/dcache_bus_pkg.sv
/*
 * data cache port types
 * CPU request/response and line-wide memory request/response
 */
`default_nettype none

`include "dcache_cfg.svh"

package dcache_bus_pkg;

    // op set means store
    typedef struct packed {
        logic                       valid;
        logic                       op;
        dcache_addr_pkg::addr_u     addr;
        logic [3:0]                 wstrb;
        logic [`DCACHE_ADDR_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`DCACHE_ADDR_W-1:0]  rdata;
    } cpu_rsp_t;

    // refill read and victim writeback, both line-aligned
    typedef struct packed {
        logic                       rd_req;
        logic [`DCACHE_ADDR_W-1:0]  rd_addr;
        logic                       wr_req;
        logic [`DCACHE_ADDR_W-1:0]  wr_addr;
        dcache_addr_pkg::line_t     wr_data;
    } mem_req_t;

    // wr_valid pulses once the writeback has landed
    typedef struct packed {
        logic                       rd_rdy;
        logic                       ret_valid;
        dcache_addr_pkg::line_t     ret_data;
        logic                       wr_rdy;
        logic                       wr_valid;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/dcache_arrays.sv
/*
 * data cache storage
 * per-way tag/valid, dirty and word-wide data arrays, registered read
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_arrays (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire  [`DCACHE_INDEX_W-1:0]                   rd_index,
    input  wire                                          rd_en,
    input  wire  dcache_addr_pkg::way_sel_t              tag_we,
    input  wire  dcache_addr_pkg::tagv_t                 tag_wdata,
    input  wire  dcache_addr_pkg::way_sel_t              dirty_we,
    input  wire                                          dirty_wdata,
    input  wire  [`DCACHE_INDEX_W-1:0]                   wr_index,
    input  wire  [`DCACHE_WAYS*`DCACHE_LINE_WORDS-1:0]   data_we,
    input  wire  dcache_addr_pkg::line_t                 data_wdata,
    output dcache_addr_pkg::tagv_t [`DCACHE_WAYS-1:0]    tagv_rdata,
    output dcache_addr_pkg::way_sel_t                    dirty_rdata,
    output dcache_addr_pkg::line_t [`DCACHE_WAYS-1:0]    data_rdata
);

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        logic [`DCACHE_TAG_W-1:0] tag_mem [`DCACHE_SETS];
        logic [`DCACHE_SETS-1:0]  valid_q;
        logic [`DCACHE_SETS-1:0]  dirty_q;
        dcache_addr_pkg::tagv_t   tagv_rd_q;
        logic                     dirty_rd_q;

        // valid and dirty need a known state out of reset
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else begin
                if (tag_we[w]) begin
                    valid_q[wr_index] <= tag_wdata.valid;
                end
                if (dirty_we[w]) begin
                    dirty_q[wr_index] <= dirty_wdata;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (tag_we[w]) begin
                tag_mem[wr_index] <= tag_wdata.tag;
            end
            // read sees the old contents on a same-edge write
            if (rd_en) begin
                tagv_rd_q.valid <= valid_q[rd_index];
                tagv_rd_q.tag   <= tag_mem[rd_index];
                dirty_rd_q      <= dirty_q[rd_index];
            end
        end

        assign tagv_rdata[w]  = tagv_rd_q;
        assign dirty_rdata[w] = dirty_rd_q;

        // one RAM per word, so a store touches one word and a refill all of them
        for (genvar k = 0; k < `DCACHE_LINE_WORDS; k++) begin : g_word
            logic [`DCACHE_ADDR_W-1:0] word_mem [`DCACHE_SETS];
            logic [`DCACHE_ADDR_W-1:0] word_rd_q;

            always_ff @(posedge clk) begin
                if (data_we[w*`DCACHE_LINE_WORDS+k]) begin
                    word_mem[wr_index] <= data_wdata[k];
                end
                if (rd_en) begin
                    word_rd_q <= word_mem[rd_index];
                end
            end

            assign data_rdata[w][k] = word_rd_q;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_lookup.sv
/*
 * data cache lookup
 * tag compare, word select, store byte merge and last-store bypass
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_lookup (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire  dcache_bus_pkg::cpu_req_t               req,
    input  wire  dcache_addr_pkg::tagv_t [`DCACHE_WAYS-1:0] tagv_rdata,
    input  wire  dcache_addr_pkg::line_t [`DCACHE_WAYS-1:0] data_rdata,
    input  wire                                          store_we,
    output dcache_addr_pkg::way_sel_t                    hit,
    output logic                                         hit_any,
    output logic [`DCACHE_ADDR_W-1:0]                    rsp_word,
    output logic [`DCACHE_ADDR_W-1:0]                    merged_word
);

    logic [1:0]                 word_idx;
    logic [`DCACHE_ADDR_W-1:0]  way_word;
    logic                       bypass;

    // last store written into the data array
    logic                       st_valid_q;
    dcache_addr_pkg::way_sel_t  st_way_q;
    dcache_addr_pkg::addr_u     st_addr_q;
    logic [`DCACHE_ADDR_W-1:0]  st_word_q;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_cmp
        assign hit[w] = tagv_rdata[w].valid && (tagv_rdata[w].tag == req.addr.f.tag);
    end

    assign hit_any = |hit;

    // upper offset bits pick the word
    assign word_idx = req.addr.f.offset[`DCACHE_OFFSET_W-1:2];
    assign way_word = data_rdata[hit[1]][word_idx];

    // array read raced the store write one edge earlier
    assign bypass = st_valid_q && (st_way_q == hit) &&
                    (st_addr_q.raw[`DCACHE_ADDR_W-1:2] == req.addr.raw[`DCACHE_ADDR_W-1:2]);

    assign rsp_word = bypass ? st_word_q : way_word;

    always_comb begin
        merged_word = rsp_word;
        for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
                merged_word[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid_q <= 1'b0;
        end else begin
            st_valid_q <= store_we;
        end
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            st_way_q  <= hit;
            st_addr_q <= req.addr;
            st_word_q <= merged_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
/*
 * data cache control
 * request register, miss FSM with writeback and refill, per-set LRU bit
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire  dcache_bus_pkg::cpu_req_t               cpu_req,
    input  wire  dcache_addr_pkg::way_sel_t              hit,
    input  wire                                          hit_any,
    input  wire  [`DCACHE_ADDR_W-1:0]                    rsp_word,
    input  wire  [`DCACHE_ADDR_W-1:0]                    merged_word,
    input  wire  dcache_addr_pkg::tagv_t [`DCACHE_WAYS-1:0] tagv_rdata,
    input  wire  dcache_addr_pkg::way_sel_t              dirty_rdata,
    input  wire  dcache_addr_pkg::line_t [`DCACHE_WAYS-1:0] data_rdata,
    input  wire  dcache_bus_pkg::mem_rsp_t               mem_rsp,
    output logic                                         busy,
    output dcache_bus_pkg::cpu_rsp_t                     cpu_rsp,
    output dcache_bus_pkg::mem_req_t                     mem_req,
    output dcache_bus_pkg::cpu_req_t                     req,
    output logic                                         store_we,
    output logic [`DCACHE_INDEX_W-1:0]                   rd_index,
    output logic                                         rd_en,
    output dcache_addr_pkg::way_sel_t                    tag_we,
    output dcache_addr_pkg::tagv_t                       tag_wdata,
    output dcache_addr_pkg::way_sel_t                    dirty_we,
    output logic                                         dirty_wdata,
    output logic [`DCACHE_INDEX_W-1:0]                   wr_index,
    output logic [`DCACHE_WAYS*`DCACHE_LINE_WORDS-1:0]   data_we,
    output dcache_addr_pkg::line_t                       data_wdata
);

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } state_t;

    state_t                    state_q, state_d;
    dcache_bus_pkg::cpu_req_t  req_q;
    logic [`DCACHE_SETS-1:0]   lru_q;
    logic                      victim;
    dcache_addr_pkg::way_sel_t victim_sel;
    dcache_addr_pkg::addr_u    fill_addr, wb_addr;
    logic                      lookup_hit, lookup_miss, refill;

    assign req         = req_q;
    assign lookup_hit  = (state_q == LOOKUP) && req_q.valid && hit_any;
    assign lookup_miss = (state_q == LOOKUP) && req_q.valid && !hit_any;
    assign busy        = (state_q != LOOKUP) || lookup_miss;
    assign store_we    = lookup_hit && req_q.op;
    assign refill      = (state_q == REFILL) && mem_rsp.ret_valid;

    // lru bit names the way to replace next
    assign victim     = lru_q[req_q.addr.f.index];
    assign victim_sel = dcache_addr_pkg::way_sel_t'(1) << victim;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LOOKUP;
            req_q   <= '0;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (!busy) begin
                req_q <= cpu_req;
            end
            if (lookup_hit) begin
                lru_q[req_q.addr.f.index] <= hit[0];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP:      if (lookup_miss) state_d = dirty_rdata[victim] ? MISS_DIRTY : MISS_CLEAN;
            MISS_DIRTY:  if (mem_rsp.wr_rdy) state_d = WRITEBACK;
            WRITEBACK:   if (mem_rsp.wr_valid) state_d = MISS_CLEAN;
            MISS_CLEAN:  if (mem_rsp.rd_rdy) state_d = REFILL;
            REFILL:      if (mem_rsp.ret_valid) state_d = REFILL_DONE;
            REFILL_DONE: state_d = LOOKUP;
            default:     state_d = LOOKUP;
        endcase
    end

    // read data stays frozen during a miss and feeds the writeback line
    assign rd_en    = !busy || (state_q == REFILL_DONE);
    assign rd_index = (state_q == REFILL_DONE) ? req_q.addr.f.index : cpu_req.addr.f.index;

    always_comb begin
        fill_addr          = req_q.addr;
        fill_addr.f.offset = '0;
        wb_addr.f.tag      = tagv_rdata[victim].tag;
        wb_addr.f.index    = req_q.addr.f.index;
        wb_addr.f.offset   = '0;
    end

    assign mem_req.rd_req  = (state_q == MISS_CLEAN);
    assign mem_req.rd_addr = fill_addr.raw;
    assign mem_req.wr_req  = (state_q == MISS_DIRTY);
    assign mem_req.wr_addr = wb_addr.raw;
    assign mem_req.wr_data = data_rdata[victim];

    // refill goes to the victim way, a store hit to one word of the hit way
    assign wr_index    = req_q.addr.f.index;
    assign tag_we      = refill ? victim_sel : '0;
    assign tag_wdata   = '{valid: 1'b1, tag: req_q.addr.f.tag};
    assign dirty_we    = refill ? victim_sel : (store_we ? hit : '0);
    assign dirty_wdata = !refill;
    assign data_wdata  = refill ? mem_rsp.ret_data : {`DCACHE_LINE_WORDS{merged_word}};

    always_comb begin
        data_we = '0;
        if (refill) begin
            data_we[victim*`DCACHE_LINE_WORDS +: `DCACHE_LINE_WORDS] = '1;
        end else if (store_we) begin
            data_we[{hit[1], req_q.addr.f.offset[`DCACHE_OFFSET_W-1:2]}] = 1'b1;
        end
    end

    // a store answers with the merged word
    assign cpu_rsp.valid = lookup_hit;
    assign cpu_rsp.rdata = req_q.op ? merged_word : rsp_word;

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
/*
 * data cache top level
 * two-way write-back cache between a CPU port and a line-wide memory port
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  dcache_bus_pkg::cpu_req_t   cpu_req,
    output logic                             busy,
    output dcache_bus_pkg::cpu_rsp_t         cpu_rsp,
    output dcache_bus_pkg::mem_req_t         mem_req,
    input  wire  dcache_bus_pkg::mem_rsp_t   mem_rsp
);

    // registered request and lookup results
    dcache_bus_pkg::cpu_req_t                   req;
    dcache_addr_pkg::way_sel_t                  hit;
    logic                                       hit_any;
    logic [`DCACHE_ADDR_W-1:0]                  rsp_word;
    logic [`DCACHE_ADDR_W-1:0]                  merged_word;
    logic                                       store_we;

    // array controls and read data
    logic [`DCACHE_INDEX_W-1:0]                 rd_index;
    logic                                       rd_en;
    dcache_addr_pkg::way_sel_t                  tag_we;
    dcache_addr_pkg::tagv_t                     tag_wdata;
    dcache_addr_pkg::way_sel_t                  dirty_we;
    logic                                       dirty_wdata;
    logic [`DCACHE_INDEX_W-1:0]                 wr_index;
    logic [`DCACHE_WAYS*`DCACHE_LINE_WORDS-1:0] data_we;
    dcache_addr_pkg::line_t                     data_wdata;
    dcache_addr_pkg::tagv_t [`DCACHE_WAYS-1:0]  tagv_rdata;
    dcache_addr_pkg::way_sel_t                  dirty_rdata;
    dcache_addr_pkg::line_t [`DCACHE_WAYS-1:0]  data_rdata;

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .hit         (hit),
        .hit_any     (hit_any),
        .rsp_word    (rsp_word),
        .merged_word (merged_word),
        .tagv_rdata  (tagv_rdata),
        .dirty_rdata (dirty_rdata),
        .data_rdata  (data_rdata),
        .mem_rsp     (mem_rsp),
        .busy        (busy),
        .cpu_rsp     (cpu_rsp),
        .mem_req     (mem_req),
        .req         (req),
        .store_we    (store_we),
        .rd_index    (rd_index),
        .rd_en       (rd_en),
        .tag_we      (tag_we),
        .tag_wdata   (tag_wdata),
        .dirty_we    (dirty_we),
        .dirty_wdata (dirty_wdata),
        .wr_index    (wr_index),
        .data_we     (data_we),
        .data_wdata  (data_wdata)
    );

    dcache_lookup u_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .tagv_rdata  (tagv_rdata),
        .data_rdata  (data_rdata),
        .store_we    (store_we),
        .hit         (hit),
        .hit_any     (hit_any),
        .rsp_word    (rsp_word),
        .merged_word (merged_word)
    );

    dcache_arrays u_arrays (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_index    (rd_index),
        .rd_en       (rd_en),
        .tag_we      (tag_we),
        .tag_wdata   (tag_wdata),
        .dirty_we    (dirty_we),
        .dirty_wdata (dirty_wdata),
        .wr_index    (wr_index),
        .data_we     (data_we),
        .data_wdata  (data_wdata),
        .tagv_rdata  (tagv_rdata),
        .dirty_rdata (dirty_rdata),
        .data_rdata  (data_rdata)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 20 ns clock, active-low reset held for four cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/dcache_assertions.sv
/*
 * data cache protocol assertions
 * memory strobe rules and CPU response spacing, bound to the cache top
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  dcache_bus_pkg::cpu_req_t cpu_req,
    input  wire                            busy,
    input  wire  dcache_bus_pkg::cpu_rsp_t cpu_rsp,
    input  wire  dcache_bus_pkg::mem_req_t mem_req,
    input  wire  dcache_bus_pkg::mem_rsp_t mem_rsp
);

    // one memory transfer at a time
    assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.rd_req && mem_req.wr_req))
        else $error("refill read and writeback requested together");

    // strobes, addresses and writeback data hold until ready
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.rd_req && !mem_rsp.rd_rdy) |=> (mem_req.rd_req && $stable(mem_req.rd_addr)))
        else $error("rd_req dropped or moved before rd_rdy");

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.wr_req && !mem_rsp.wr_rdy) |=>
            (mem_req.wr_req && $stable(mem_req.wr_addr) && $stable(mem_req.wr_data)))
        else $error("wr_req dropped or moved before wr_rdy");

    // back-to-back responses need a request taken while busy was low
    assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_rsp.valid && !(cpu_req.valid && !busy)) |=> !cpu_rsp.valid)
        else $error("two responses without a request accepted in between");

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .busy    (busy),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

`default_nettype wire

// File: tests/tb_dcache.sv
/*
 * data cache testbench
 * directed tests against a line-wide memory model and a word shadow
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MAX_MEM_DELAY  = 5;
    localparam int RANDOM_OPS     = 200;

    logic                     clk;
    logic                     rst_n;
    dcache_bus_pkg::cpu_req_t cpu_req;
    logic                     busy;
    dcache_bus_pkg::cpu_rsp_t cpu_rsp;
    dcache_bus_pkg::mem_req_t mem_req;
    dcache_bus_pkg::mem_rsp_t mem_rsp;

    // backing memory and what the CPU should see, both word-addressed
    logic [31:0] mem_words [logic [29:0]];
    logic [31:0] shadow    [logic [29:0]];

    int          rd_count    = 0;
    int          wr_count    = 0;
    logic [31:0] last_rd_addr = '0;
    logic [31:0] wb_addrs[$];
    int          errors      = 0;
    int          tests_run   = 0;
    int          test_errors = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dcache_top u_dcache_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .busy    (busy),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    function automatic logic [31:0] mem_read(input logic [31:0] byte_addr);
        if (mem_words.exists(byte_addr[31:2])) begin
            return mem_words[byte_addr[31:2]];
        end
        return {byte_addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] byte_addr);
        if (shadow.exists(byte_addr[31:2])) begin
            return shadow[byte_addr[31:2]];
        end
        return {byte_addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [`DCACHE_TAG_W-1:0] tag,
                                              input logic [`DCACHE_INDEX_W-1:0] index,
                                              input logic [1:0] word);
        dcache_addr_pkg::addr_u a;
        a.f.tag    = tag;
        a.f.index  = index;
        a.f.offset = {word, 2'b00};
        return a.raw;
    endfunction

    function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        test_errors++;
    endtask

    task automatic report_problem(input string name, input string what);
        $display("%s: %s", name, what);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %s done with %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic mem_delay();
        int d;
        d = $urandom_range(MAX_MEM_DELAY, 0);
        repeat (d) begin
            @(posedge clk);
            #2;
        end
    endtask

    // memory model, one transfer at a time with random ready and return delays
    initial begin : memory_model
        dcache_addr_pkg::line_t line;
        logic [31:0]            addr;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req.wr_req) begin
                addr = mem_req.wr_addr;
                line = mem_req.wr_data;
                mem_delay();
                mem_rsp.wr_rdy = 1'b1;
                @(posedge clk);
                #2;
                mem_rsp.wr_rdy = 1'b0;
                for (int k = 0; k < `DCACHE_LINE_WORDS; k++) begin
                    mem_words[addr[31:2] + 30'(k)] = line[k];
                end
                wb_addrs.push_back(addr);
                wr_count++;
                mem_delay();
                mem_rsp.wr_valid = 1'b1;
                @(posedge clk);
                #2;
                mem_rsp.wr_valid = 1'b0;
            end else if (mem_req.rd_req) begin
                addr         = mem_req.rd_addr;
                last_rd_addr = addr;
                rd_count++;
                mem_delay();
                mem_rsp.rd_rdy = 1'b1;
                @(posedge clk);
                #2;
                mem_rsp.rd_rdy = 1'b0;
                mem_delay();
                for (int k = 0; k < `DCACHE_LINE_WORDS; k++) begin
                    mem_rsp.ret_data[k] = mem_read(addr + 32'(4 * k));
                end
                mem_rsp.ret_valid = 1'b1;
                @(posedge clk);
                #2;
                mem_rsp.ret_valid = 1'b0;
            end
        end
    end

    // returns in the response cycle, so the next call issues back-to-back
    task automatic access(input string name, input logic op, input logic [31:0] addr,
                          input logic [3:0] strb, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int lat,
                          output logic saw_busy);
        int   t;
        logic accepted;
        rdata    = '0;
        lat      = -1;
        saw_busy = 1'b0;
        accepted = 1'b0;
        t        = 0;
        cpu_req.valid    = 1'b1;
        cpu_req.op       = op;
        cpu_req.addr.raw = addr;
        cpu_req.wstrb    = strb;
        cpu_req.wdata    = wdata;
        // taken at the edge after a cycle with busy low
        while (!accepted && t < TIMEOUT_CYCLES) begin
            accepted = !busy;
            @(posedge clk);
            #2;
            t++;
        end
        cpu_req.valid = 1'b0;
        if (!accepted) begin
            report_problem(name, "request was never accepted, busy stayed high");
            return;
        end
        t = 1;
        while (!cpu_rsp.valid && t < TIMEOUT_CYCLES) begin
            saw_busy = saw_busy | busy;
            @(posedge clk);
            #2;
            t++;
        end
        if (!cpu_rsp.valid) begin
            report_problem(name, "no response arrived before the timeout");
            return;
        end
        saw_busy = saw_busy | busy;
        rdata    = cpu_rsp.rdata;
        lat      = t;
    endtask

    task automatic do_load(input string name, input logic [31:0] addr,
                           output int lat, output logic saw_busy);
        logic [31:0] exp;
        logic [31:0] got;
        exp = shadow_read(addr);
        access(name, 1'b0, addr, 4'h0, 32'h0, got, lat, saw_busy);
        if (lat >= 0 && got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic do_store(input string name, input logic [31:0] addr,
                            input logic [3:0] strb, input logic [31:0] wdata);
        logic [31:0] exp;
        logic [31:0] got;
        int          lat;
        logic        saw_busy;
        exp = byte_merge(shadow_read(addr), wdata, strb);
        shadow[addr[31:2]] = exp;
        access(name, 1'b1, addr, strb, wdata, got, lat, saw_busy);
        if (lat >= 0 && got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic test_reset_and_miss();
        string       name;
        logic [31:0] addr;
        int          lat;
        int          rd_before;
        logic        saw_busy;
        name = "reset_and_miss";
        if (busy !== 1'b0 || cpu_rsp.valid !== 1'b0) begin
            report_problem(name, "busy or response valid is not low after reset");
        end
        if (mem_req.rd_req !== 1'b0 || mem_req.wr_req !== 1'b0) begin
            report_problem(name, "a memory request is active after reset");
        end
        addr      = make_addr(24'h000010, 4'h2, 2'd1);
        rd_before = rd_count;
        do_load(name, addr, lat, saw_busy);
        if (rd_count != rd_before + 1) report_mismatch(name, rd_before + 1, rd_count);
        if (last_rd_addr !== {addr[31:4], 4'h0}) begin
            report_mismatch(name, {addr[31:4], 4'h0}, last_rd_addr);
        end
        if (!saw_busy) report_problem(name, "busy never rose during the miss");
        finish_test(name);
    endtask

    task automatic test_repeat_hit();
        string name;
        int    lat;
        int    rd_before;
        int    wr_before;
        logic  saw_busy;
        name      = "repeat_hit";
        rd_before = rd_count;
        wr_before = wr_count;
        do_load(name, make_addr(24'h000010, 4'h2, 2'd3), lat, saw_busy);
        if (lat != 1) report_mismatch(name, 1, lat);
        if (saw_busy) report_problem(name, "busy rose on a hit");
        if (rd_count != rd_before || wr_count != wr_before) begin
            report_problem(name, "a hit issued a memory request");
        end
        finish_test(name);
    endtask

    task automatic test_store_bypass();
        string       name;
        logic [31:0] addr;
        int          lat;
        int          rd_before;
        logic        saw_busy;
        name      = "store_bypass";
        addr      = make_addr(24'h000010, 4'h2, 2'd2);
        rd_before = rd_count;
        // each load follows its store with no idle cycle
        do_store(name, addr, 4'b0101, 32'hdead_beef);
        do_load(name, addr, lat, saw_busy);
        do_store(name, addr, 4'b1000, 32'h7700_0000);
        do_load(name, addr, lat, saw_busy);
        if (lat != 1) report_mismatch(name, 1, lat);
        if (rd_count != rd_before) report_problem(name, "a store hit caused a refill");
        finish_test(name);
    endtask

    task automatic test_eviction();
        string       name;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        int          lat;
        int          rd_before;
        int          wr_before;
        logic        saw_busy;
        name = "eviction";
        a1   = make_addr(24'h000a01, 4'h7, 2'd1);
        a2   = make_addr(24'h000a02, 4'h7, 2'd0);
        a3   = make_addr(24'h000a03, 4'h7, 2'd2);
        do_load(name, a1, lat, saw_busy);
        do_load(name, a2, lat, saw_busy);
        // dirty T1, then touch T2 so T1 is least recently used
        do_store(name, a1, 4'b1100, 32'hcafe_f00d);
        do_load(name, a2, lat, saw_busy);
        rd_before = rd_count;
        wr_before = wr_count;
        do_load(name, a3, lat, saw_busy);
        if (wr_count != wr_before + 1) begin
            report_mismatch(name, wr_before + 1, wr_count);
        end else if (wb_addrs[$] !== {a1[31:4], 4'h0}) begin
            report_mismatch(name, {a1[31:4], 4'h0}, wb_addrs[$]);
        end
        if (mem_read(a1) !== shadow_read(a1)) report_mismatch(name, shadow_read(a1), mem_read(a1));
        if (rd_count != rd_before + 1) report_mismatch(name, rd_before + 1, rd_count);
        // T1 comes back from memory, replacing the clean T2
        rd_before = rd_count;
        wr_before = wr_count;
        do_load(name, a1, lat, saw_busy);
        if (rd_count != rd_before + 1) report_problem(name, "reload of T1 did not miss");
        if (wr_count != wr_before) report_problem(name, "clean T2 was written back");
        finish_test(name);
    endtask

    task automatic test_clean_victim();
        string name;
        int    lat;
        int    rd_before;
        int    wr_before;
        logic  saw_busy;
        name      = "clean_victim";
        rd_before = rd_count;
        wr_before = wr_count;
        for (int t = 1; t <= 3; t++) begin
            do_load(name, make_addr(24'h000b00 + 24'(t), 4'hb, 2'(t)), lat, saw_busy);
        end
        if (rd_count != rd_before + 3) report_mismatch(name, rd_before + 3, rd_count);
        if (wr_count != wr_before) report_problem(name, "a clean victim caused a writeback");
        finish_test(name);
    endtask

    task automatic test_random();
        string       name;
        logic [31:0] addr;
        int          lat;
        logic        saw_busy;
        name = "random";
        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = make_addr(24'h000c00 + 24'($urandom_range(3, 0)),
                             4'($urandom_range(3, 0)), 2'($urandom_range(3, 0)));
            if ($urandom_range(1, 0) == 1) begin
                do_store(name, addr, 4'($urandom_range(15, 1)), $urandom);
            end else begin
                do_load(name, addr, lat, saw_busy);
            end
        end
        finish_test(name);
    endtask

    initial begin : main
        int t;
        void'($urandom(32'hc267c063));
        cpu_req = '0;
        t = 0;
        while (rst_n !== 1'b1 && t < TIMEOUT_CYCLES) begin
            @(posedge clk);
            t++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end else begin
            @(posedge clk);
            #2;
            test_reset_and_miss();
            test_repeat_hit();
            test_store_bypass();
            test_eviction();
            test_clean_victim();
            test_random();
        end
        $display("summary: %0d tests run, %0d errors, %0d writebacks, %0d refills",
                 tests_run, errors, wr_count, rd_count);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/dcache_addr_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/dcache_arrays.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tests/tb_clock_gen.sv
tests/dcache_assertions.sv
tests/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_addr_pkg.sv
      - rtl/dcache_bus_pkg.sv
      - rtl/dcache_arrays.sv
      - rtl/dcache_lookup.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/dcache_assertions.sv
      - tests/tb_dcache.sv
